/* sim.f */
verilog/wb_pkg.sv
verilog/wb_if.sv
verilog/wb_addr_decode.sv
verilog/soc_mem.sv
verilog/mem_wb.sv
verilog/wb_regs.sv
verilog/wb_resp_mux.sv
verilog/wb_subsys_top.sv
testbench/tb_wb_subsys.sv

/* testbench/tb_wb_subsys.sv */
`timescale 1ns/1ps

module tb_wb_subsys
    import wb_pkg::*;
();

    localparam int  MEM_WORDS  = 256;
    localparam time CLK_PERIOD = 100ns;
    localparam time DRV_DLY    = 10ns;
    localparam int  RESP_LIMIT = 8;       // Negedges to wait for ack or err.

    // Transfer counts per test group.
    localparam int N_FULL  = 40;
    localparam int N_SEL   = 30;
    localparam int N_REG   = 30;
    localparam int N_UNMAP = 10;
    localparam int N_B2B   = 12;
    localparam int N_HOLD  = 8;
    localparam int TOTAL_XFERS = 1 + MEM_WORDS + 2 + 2 * N_FULL + 2 * N_SEL + 2 + N_REG + 8
                               + N_UNMAP + N_B2B + N_HOLD;

    logic              clk;
    logic              rst_n;
    logic [WB_AW-1:0]  wb_adr;
    logic [WB_DW-1:0]  wb_dat;
    logic [WB_SW-1:0]  wb_sel;
    logic              wb_we;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_ack;
    logic              wb_err;
    logic [WB_DW-1:0]  wb_dat_r;

    logic [31:0] rng_state = 32'h264c35f7;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;

    // Shadow state for the reference model.
    logic [31:0] shadow_mem [0:MEM_WORDS-1];
    logic [31:0] shadow_reg [0:7];

    // Expected and observed responses, one entry per transfer.
    string       name_q [$];
    logic [31:0] exp_data_q [$];
    bit          exp_err_q [$];
    bit          data_chk_q [$];
    int          act_kind_q [$];     // 0 none, 1 ack, 2 err, 3 both.
    logic [31:0] act_data_q [$];
    int          act_wait_q [$];
    event        resp_ev;

    wb_subsys_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .wb_dat_o (wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        next_random = rng_state;
    endfunction

    function automatic bit is_unmapped(input logic [31:0] adr);
        is_unmapped = (adr[31:28] != REGION_MEM) && (adr[31:28] != REGION_REG);
    endfunction

    // Updates the shadows and returns the word a read of adr sees.
    function automatic logic [31:0] ref_access(input logic [31:0] adr, input logic [31:0] dat,
                                               input logic [3:0] sel, input logic we);
        logic [31:0] old;
        int          w;
        int          idx;
        old = 32'h0;
        if (adr[31:28] == REGION_MEM) begin
            w   = adr[23:2] & (MEM_WORDS - 1);     // Word index wraps.
            old = shadow_mem[w];
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) shadow_mem[w][8*b +: 8] = dat[8*b +: 8];
                end
            end
        end else if (adr[31:28] == REGION_REG) begin
            idx = adr[4:2];
            old = (idx == 0) ? REG_ID_VALUE : shadow_reg[idx];
            if (we && idx != 0) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) shadow_reg[idx][8*b +: 8] = dat[8*b +: 8];
                end
            end
        end
        ref_access = old;                  // Unmapped reads give zero.
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    // One Wishbone transfer. With keep set stb stays high for the next request.
    task automatic bus_xfer(input string name, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we, input bit keep);
        int waits;
        bit got;
        name_q.push_back(name);
        exp_data_q.push_back(ref_access(adr, dat, sel, we));
        exp_err_q.push_back(is_unmapped(adr));
        data_chk_q.push_back(!we || is_unmapped(adr));
        @(posedge clk);
        #DRV_DLY;
        wb_adr = adr;
        wb_dat = dat;
        wb_sel = sel;
        wb_we  = we;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        waits  = 0;
        got    = 1'b0;
        while (!got && waits < RESP_LIMIT) begin
            @(negedge clk);                // Outputs settled mid-cycle.
            waits++;
            got = wb_ack | wb_err;
        end
        act_kind_q.push_back(got ? {wb_err, wb_ack} : 0);
        act_data_q.push_back(wb_dat_r);
        act_wait_q.push_back(waits);
        -> resp_ev;
        if (!keep) begin
            @(posedge clk);
            #DRV_DLY;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    // Compare process.
    initial begin
        string       name;
        logic [31:0] exp;
        logic [31:0] act;
        bit          exp_err;
        bit          chk;
        int          kind;
        int          waits;
        forever begin
            @(resp_ev);
            while (act_kind_q.size() > 0) begin
                name    = name_q.pop_front();
                exp     = exp_data_q.pop_front();
                exp_err = exp_err_q.pop_front();
                chk     = data_chk_q.pop_front();
                kind    = act_kind_q.pop_front();
                act     = act_data_q.pop_front();
                waits   = act_wait_q.pop_front();
                if (kind == 0) begin
                    $display("ERROR %s: no response from the DUT", name);
                    fail_cnt++;
                end else if (kind == 3) begin
                    $display("ERROR %s: ack and err raised together", name);
                    fail_cnt++;
                end else if (exp_err && kind != 2) begin
                    $display("ERROR %s: got ack where err was expected", name);
                    fail_cnt++;
                end else if (!exp_err && kind != 1) begin
                    $display("ERROR %s: got err where ack was expected", name);
                    fail_cnt++;
                end else begin
                    // Request is seen one edge after the drive and answered one cycle later.
                    if (waits != 2) begin
                        $display("ERROR %s: response came %0d cycles after the request, not 1",
                                 name, waits - 1);
                        fail_cnt++;
                    end
                    if (chk) check_value(name, exp, act);
                end
            end
        end
    end

    // Watchdog.
    initial begin
        #((TOTAL_XFERS * 4 + 100) * CLK_PERIOD);
        $display("ERROR: timeout, the tests did not finish in time");
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
        $display("=== FAIL ===");
        $finish;
    end

    // Stimulus.
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  rg;
        for (int k = 0; k < 8; k++) shadow_reg[k] = 32'h0;   // Cleared by reset.
        rst_n  = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        wb_sel = '0;
        wb_we  = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        // Idle outputs after reset and the first response.
        @(negedge clk);
        check_value("reset_ack", 32'h0, {31'h0, wb_ack});
        check_value("reset_err", 32'h0, {31'h0, wb_err});
        check_value("reset_dat", 32'h0, wb_dat_r);
        bus_xfer("first_response", {REGION_REG, 28'h0}, 32'h0, 4'hf, 1'b0, 1'b0);

        // Fill pattern built from the whole address.
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i * 4;
            bus_xfer("mem_fill", a, (a * 32'h9e3779b1) ^ 32'h0f1e2d3c, 4'hf, 1'b1, 1'b0);
        end

        // Alias through the word-index wrap.
        a = (5 + MEM_WORDS) * 4;
        bus_xfer("mem_alias_wr", a, 32'hcafe_f00d, 4'hf, 1'b1, 1'b0);
        bus_xfer("mem_alias_rd", 32'h14, 32'h0, 4'hf, 1'b0, 1'b0);

        for (int i = 0; i < N_FULL; i++) begin
            r = next_random();
            a = {REGION_MEM, r[27:0]};     // Index bits above MEM_WORDS too.
            d = next_random();
            bus_xfer($sformatf("mem_full_wr[%0d]", i), a, d, 4'hf, 1'b1, 1'b0);
            r = next_random();
            bus_xfer($sformatf("mem_full_rd[%0d]", i), {REGION_MEM, r[27:0]}, 32'h0, 4'hf,
                     1'b0, 1'b0);
        end

        // Byte-lane merges.
        for (int i = 0; i < N_SEL; i++) begin
            r = next_random();
            a = {REGION_MEM, r[27:0]};
            d = next_random();
            bus_xfer($sformatf("mem_sel_wr[%0d]", i), a, d, r[31:28], 1'b1, 1'b0);
            bus_xfer($sformatf("mem_sel_rd[%0d]", i), a, 32'h0, 4'hf, 1'b0, 1'b0);
        end

        // Register 0 stays the ID word.
        bus_xfer("reg0_wr", {REGION_REG, 28'h0}, 32'hffff_ffff, 4'hf, 1'b1, 1'b0);
        bus_xfer("reg0_rd", {REGION_REG, 28'h0}, 32'h0, 4'hf, 1'b0, 1'b0);
        for (int i = 0; i < N_REG; i++) begin
            r = next_random();
            d = next_random();
            bus_xfer($sformatf("reg_rw[%0d]", i), {REGION_REG, r[27:0]}, d, r[31:28], r[8],
                     1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            bus_xfer($sformatf("reg_dump[%0d]", i), {REGION_REG, 28'h0} | (i * 4), 32'h0,
                     4'hf, 1'b0, 1'b0);
        end

        // Unmapped regions answer with err.
        for (int i = 0; i < N_UNMAP; i++) begin
            r  = next_random();
            rg = r[31:28];
            if (rg < 4'h2) rg = rg + 4'h2;
            bus_xfer($sformatf("unmapped[%0d]", i), {rg, r[27:0]}, next_random(), 4'hf,
                     r[0], 1'b0);
        end

        // Back-to-back transfers with stb never dropped.
        for (int i = 0; i < N_B2B; i++) begin
            r = next_random();
            case (i % 3)
                0: a = {REGION_MEM, r[27:0]};
                1: a = {REGION_REG, r[27:0]};
                default: a = {4'h7, r[27:0]};
            endcase
            bus_xfer($sformatf("b2b[%0d]", i), a, next_random(), 4'hf, r[9],
                     (i != N_B2B - 1));
        end

        // One read held for several cycles gets an ack every second cycle.
        @(posedge clk);
        #DRV_DLY;
        wb_adr = 32'h40;
        wb_we  = 1'b0;
        wb_sel = 4'hf;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        for (int i = 1; i <= N_HOLD; i++) begin
            @(negedge clk);
            check_value($sformatf("hold_stb_ack[%0d]", i), {31'h0, (i % 2 == 0)},
                        {31'h0, wb_ack});
        end
        @(posedge clk);
        #DRV_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;

        repeat (3) @(posedge clk);
        if (act_kind_q.size() != 0) begin
            $display("ERROR: %0d responses were never compared", act_kind_q.size());
            fail_cnt++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog/wb_subsys_top.sv */
`timescale 1ns/1ps

module wb_subsys_top
    import wb_pkg::*;
#(
    parameter int MEM_WORDS = 256     // Power of two.
) (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic [WB_AW-1:0]  wb_adr_i,
    input  logic [WB_DW-1:0]  wb_dat_i,
    input  logic [WB_SW-1:0]  wb_sel_i,
    input  logic              wb_we_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,

    output logic              wb_ack_o,
    output logic              wb_err_o,
    output logic [WB_DW-1:0]  wb_dat_o
);

    logic unmapped_stb;

    wb_if mem_bus ();
    wb_if reg_bus ();

    // Decode.
    wb_addr_decode u_decode (
        .adr_i          (wb_adr_i),
        .dat_i          (wb_dat_i),
        .sel_i          (wb_sel_i),
        .we_i           (wb_we_i),
        .cyc_i          (wb_cyc_i),
        .stb_i          (wb_stb_i),
        .mem_o          (mem_bus.master),
        .reg_o          (reg_bus.master),
        .unmapped_stb_o (unmapped_stb)
    );

    // Execute.
    mem_wb #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus_i   (mem_bus.slave)
    );

    wb_regs u_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus_i   (reg_bus.slave)
    );

    // Result.
    wb_resp_mux u_resp (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_i          (mem_bus.monitor),
        .reg_i          (reg_bus.monitor),
        .unmapped_stb_i (unmapped_stb),
        .ack_o          (wb_ack_o),
        .err_o          (wb_err_o),
        .dat_o          (wb_dat_o)
    );

endmodule

/* verilog/wb_resp_mux.sv */
`timescale 1ns/1ps

module wb_resp_mux
    import wb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    wb_if.monitor             mem_i,
    wb_if.monitor             reg_i,
    input  logic              unmapped_stb_i,
    output logic              ack_o,
    output logic              err_o,
    output logic [WB_DW-1:0]  dat_o
);

    logic err_q;

    // Only one slave can answer at a time.
    assign ack_o = mem_i.ack | reg_i.ack;

    always_comb begin
        if (mem_i.ack) begin
            dat_o = mem_i.dat_r;
        end else if (reg_i.ack) begin
            dat_o = reg_i.dat_r;
        end else begin
            dat_o = '0;           // Idle bus and err cycles read zero.
        end
    end

    // Error responder for unmapped regions.
    // Blocked right after its own err, like the slave acks.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped_stb_i & ~err_q;
        end
    end

    assign err_o = err_q;

endmodule

/* verilog/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs
    import wb_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus_i
);

    localparam int NUM_REGS = 8;

    logic              valid;
    logic              accept;
    logic              ack_q;
    logic [2:0]        idx;
    logic [WB_DW-1:0]  rd_word;
    logic [WB_DW-1:0]  rdata_q;

    // Register 0 is the ID word and has no storage.
    logic [WB_DW-1:0]  regs_q [1:NUM_REGS-1];

    assign valid  = bus_i.cyc & bus_i.stb;
    assign accept = valid & ~ack_q;     // Same one-cycle rule as memory.
    assign idx    = bus_i.adr.regs.index;

    // Read mux.
    always_comb begin
        if (idx == 3'd0) begin
            rd_word = REG_ID_VALUE;
        end else begin
            rd_word = regs_q[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            ack_q <= accept;
            // Writes to register 0 are acked and dropped.
            if (accept && bus_i.we && (idx != 3'd0)) begin
                for (int b = 0; b < WB_SW; b++) begin
                    if (bus_i.sel[b]) begin
                        regs_q[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read word captured with the request, shown in the ack cycle.
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= rd_word;
        end
    end

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = rdata_q;

endmodule

/* verilog/mem_wb.sv */
`timescale 1ns/1ps

module mem_wb
    import wb_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus_i
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic              valid;
    logic              accept;
    logic              ack_q;
    logic [WB_SW-1:0]  wen;       // Per-byte write enables.
    logic [AW-1:0]     word_addr;
    logic [WB_DW-1:0]  rdata;

    assign valid  = bus_i.cyc & bus_i.stb;

    // A request held through its ack cycle is not taken twice.
    assign accept = valid & ~ack_q;

    assign wen = bus_i.sel & {WB_SW{bus_i.we & accept}};

    // Word index wraps modulo MEM_WORDS.
    assign word_addr = bus_i.adr.mem.word[AW-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;      // One cycle after the request.
        end
    end

    soc_mem #(
        .WORDS   (MEM_WORDS)
    ) u_mem (
        .clk     (clk),
        .ena_i   (accept),
        .wen_i   (wen),
        .addr_i  (word_addr),
        .wdata_i (bus_i.dat_w),
        .rdata_o (rdata)
    );

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = rdata;   // Registered inside soc_mem.

endmodule

/* verilog/soc_mem.sv */
`timescale 1ns/1ps

module soc_mem
    import wb_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  logic                                       clk,
    input  logic                                       ena_i,
    input  logic [WB_SW-1:0]                           wen_i,
    input  logic [((WORDS > 1) ? $clog2(WORDS) : 1)-1:0] addr_i,
    input  logic [WB_DW-1:0]                           wdata_i,
    output logic [WB_DW-1:0]                           rdata_o
);

    logic [WB_DW-1:0] mem [0:WORDS-1];

    always_ff @(posedge clk) begin
        if (ena_i) begin
            rdata_o <= mem[addr_i];   // Old word on read during write.
            for (int b = 0; b < WB_SW; b++) begin
                if (wen_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/wb_addr_decode.sv */
`timescale 1ns/1ps

module wb_addr_decode
    import wb_pkg::*;
(
    input  wb_addr_u          adr_i,
    input  logic [WB_DW-1:0]  dat_i,
    input  logic [WB_SW-1:0]  sel_i,
    input  logic              we_i,
    input  logic              cyc_i,
    input  logic              stb_i,

    wb_if.master              mem_o,
    wb_if.master              reg_o,
    output logic              unmapped_stb_o
);

    logic [3:0] region;
    logic       hit_mem;
    logic       hit_reg;
    logic       req;

    // Region field sits at the same place in both views.
    assign region  = adr_i.mem.region;
    assign hit_mem = (region == REGION_MEM);
    assign hit_reg = (region == REGION_REG);
    assign req     = cyc_i & stb_i;

    // Memory link.
    assign mem_o.adr   = adr_i;
    assign mem_o.dat_w = dat_i;
    assign mem_o.sel   = sel_i;
    assign mem_o.we    = we_i;
    assign mem_o.cyc   = cyc_i;
    assign mem_o.stb   = stb_i & hit_mem;

    // Register link.
    assign reg_o.adr   = adr_i;
    assign reg_o.dat_w = dat_i;
    assign reg_o.sel   = sel_i;
    assign reg_o.we    = we_i;
    assign reg_o.cyc   = cyc_i;
    assign reg_o.stb   = stb_i & hit_reg;

    // Unowned address. The result stage answers with err.
    assign unmapped_stb_o = req & ~hit_mem & ~hit_reg;

endmodule

/* verilog/wb_if.sv */
`timescale 1ns/1ps

// Link from the address decoder to one slave.
interface wb_if
    import wb_pkg::*;
();

    wb_addr_u          adr;
    logic [WB_DW-1:0]  dat_w;     // Write data from the master side.
    logic [WB_SW-1:0]  sel;
    logic              we;
    logic              cyc;
    logic              stb;
    logic              ack;
    logic [WB_DW-1:0]  dat_r;     // Read data, valid with ack.

    // Decoder side.
    modport master (
        output adr, dat_w, sel, we, cyc, stb,
        input  ack, dat_r
    );

    // Slave side.
    modport slave (
        input  adr, dat_w, sel, we, cyc, stb,
        output ack, dat_r
    );

    // Response collector only watches the answer.
    modport monitor (
        input ack, dat_r
    );

endinterface

/* verilog/wb_pkg.sv */
package wb_pkg;

    // Bus widths.
    localparam int WB_DW = 32;          // Data.
    localparam int WB_AW = 32;          // Address.
    localparam int WB_SW = WB_DW / 8;   // Byte selects.

    // Region codes in address bits 31:28.
    localparam logic [3:0] REGION_MEM = 4'h0;
    localparam logic [3:0] REGION_REG = 4'h1;

    // Value returned by control register 0.
    localparam logic [WB_DW-1:0] REG_ID_VALUE = 32'h5742_0101;

    // The same bus address seen by the two slaves.
    // Memory view uses a word index, register view a register index.
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [3:0]  unused;        // Gap between region and word index.
            logic [21:0] word;
            logic [1:0]  byte_off;
        } mem;
        struct packed {
            logic [3:0]  region;
            logic [22:0] unused;
            logic [2:0]  index;         // One of eight control registers.
            logic [1:0]  byte_off;
        } regs;
    } wb_addr_u;

endpackage
